//--- include/stream_buffer_macros.svh
`ifndef STREAM_BUFFER_MACROS_SVH
`define STREAM_BUFFER_MACROS_SVH

// ----------------------------------------------------------------------
// feature bank geometry.
// ----------------------------------------------------------------------

`define SB_ADDR_W 15
`define SB_DEPTH 24200

// cycles from an issued read address to its word at the bank output.
`define SB_READ_LAT 3

// ----------------------------------------------------------------------
// APB register byte offsets.
// ----------------------------------------------------------------------

`define SB_REG_CTRL 4'h0
`define SB_REG_WINDOWS 4'h4
`define SB_REG_STATUS 4'h8

`endif

//--- src/stream_buffer_pkg.sv
`default_nettype none

`include "stream_buffer_macros.svh"

package stream_buffer_pkg;

	typedef logic [15:0] feature_t;

	typedef logic [`SB_ADDR_W-1:0] bank_addr_t;

	// window count minus one. 4838 is the largest value that keeps the
	// last window inside the bank.
	typedef logic [12:0] win_count_t;

	typedef enum logic [1:0] {
		IDLE,
		WALK,
		DRAIN,
		DONE
	} walk_state_t;

endpackage

`default_nettype wire

//--- src/stream_buffer_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "stream_buffer_macros.svh"

module stream_buffer_regs (
	input wire logic clk,
	input wire logic i_reset,
	input wire logic i_psel,
	input wire logic i_penable,
	input wire logic i_pwrite,
	input wire logic [3:0] i_paddr,
	input wire logic [31:0] i_pwdata,
	input wire logic i_busy,
	input wire logic i_done_evt,
	output logic [31:0] o_prdata,
	output logic o_pready,
	output logic o_pslverr,
	output logic o_start,
	output stream_buffer_pkg::win_count_t o_windows
);

	import stream_buffer_pkg::*;

	logic access;
	logic wr_access;
	win_count_t windows_q;
	logic done_q;

	// pready is tied high, so every transfer finishes in its access phase.
	assign access = i_psel && i_penable;
	assign wr_access = access && i_pwrite;
	assign o_pready = 1'b1;

	assign o_start = wr_access && (i_paddr == `SB_REG_CTRL) && i_pwdata[0];
	assign o_windows = windows_q;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			windows_q <= '0;
			done_q <= 1'b0;
		end else begin
			if (wr_access && (i_paddr == `SB_REG_WINDOWS) && !i_busy) begin
				windows_q <= i_pwdata[$bits(win_count_t)-1:0];
			end
			// the done event wins over a start landing in the same cycle.
			if (i_done_evt) begin
				done_q <= 1'b1;
			end else if (o_start) begin
				done_q <= 1'b0;
			end
		end
	end

	// ----------------------------------------------------------------------
	// read data and slave error decode.
	// ----------------------------------------------------------------------

	always_comb begin
		o_prdata = '0;
		o_pslverr = 1'b0;
		if (access) begin
			case (i_paddr)
				`SB_REG_CTRL: begin
					o_prdata = '0;
				end
				`SB_REG_WINDOWS: begin
					o_prdata = 32'(windows_q);
					o_pslverr = i_pwrite && i_busy;
				end
				`SB_REG_STATUS: begin
					o_prdata = {30'd0, done_q, i_busy};
					o_pslverr = i_pwrite;
				end
				default: begin
					o_pslverr = 1'b1;
				end
			endcase
		end
	end

	// a well formed APB master never holds one access phase for two cycles.
	start_single_cycle: assert property (@(posedge clk) disable iff (i_reset)
		o_start |=> !o_start)
		else $error("start pulse lasted more than one cycle");

endmodule

`default_nettype wire

//--- src/stream_walk_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "stream_buffer_macros.svh"

module stream_walk_ctrl (
	input wire logic clk,
	input wire logic i_reset,
	input wire logic i_start,
	input wire logic i_last,
	output logic o_walk_en,
	output logic o_busy,
	output logic o_done
);

	import stream_buffer_pkg::*;

	localparam int DRAIN_W = $clog2(`SB_READ_LAT);

	walk_state_t state;
	logic [DRAIN_W-1:0] drain_cnt;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state <= IDLE;
			drain_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (i_start) begin
						state <= WALK;
					end
				end
				WALK: begin
					drain_cnt <= '0;
					if (i_last) begin
						state <= DRAIN;
					end
				end
				DRAIN: begin
					// wait until the last read has left the bank pipeline.
					if (drain_cnt == DRAIN_W'(`SB_READ_LAT - 1)) begin
						state <= DONE;
					end else begin
						drain_cnt <= drain_cnt + 1'b1;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	assign o_walk_en = (state == WALK);
	assign o_busy = (state != IDLE);
	assign o_done = (state == DONE);

	// a start while a walk is running is dropped by the FSM.
	start_only_when_idle: assert property (@(posedge clk) disable iff (i_reset)
		i_start |-> (state == IDLE))
		else $error("start received while the stream walk was busy");

endmodule

`default_nettype wire

//--- src/window_addr_walker.sv
`timescale 1ns/10ps
`default_nettype none

`include "stream_buffer_macros.svh"

module window_addr_walker (
	input wire logic clk,
	input wire logic i_reset,
	input wire logic i_en,
	input wire stream_buffer_pkg::win_count_t i_windows,
	output stream_buffer_pkg::bank_addr_t o_raddr,
	output logic o_ren,
	output logic o_last
);

	import stream_buffer_pkg::*;

	logic [1:0] line_cnt;
	logic chan_cnt;
	win_count_t win_cnt;
	bank_addr_t win_base;
	bank_addr_t base;
	logic [2:0] offset;
	logic line_end;
	logic window_end;

	assign line_end = (line_cnt == 2'd2);
	assign window_end = line_end && chan_cnt;

	assign o_raddr = base + bank_addr_t'(offset);
	assign o_ren = i_en;
	assign o_last = i_en && window_end && (win_cnt == i_windows);

	// ----------------------------------------------------------------------
	// line is the innermost loop, then channel, then window.
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (i_reset) begin
			line_cnt <= '0;
			chan_cnt <= 1'b0;
			win_cnt <= '0;
			win_base <= '0;
			base <= '0;
			offset <= '0;
		end else if (i_en) begin
			if (o_last) begin
				line_cnt <= '0;
				chan_cnt <= 1'b0;
				win_cnt <= '0;
				win_base <= '0;
				base <= '0;
				offset <= '0;
			end else if (window_end) begin
				line_cnt <= '0;
				chan_cnt <= 1'b0;
				win_cnt <= win_cnt + 1'b1;
				win_base <= win_base + bank_addr_t'(5);
				base <= win_base + bank_addr_t'(5);
				offset <= '0;
			end else if (line_end) begin
				line_cnt <= '0;
				chan_cnt <= 1'b1;
				base <= base + bank_addr_t'(1);
				offset <= '0;
			end else begin
				line_cnt <= line_cnt + 1'b1;
				offset <= offset + 3'd2;
			end
		end
	end

	raddr_in_bank: assert property (@(posedge clk) disable iff (i_reset)
		o_ren |-> (o_raddr < `SB_DEPTH))
		else $error("walker address %0d is outside the bank", o_raddr);

endmodule

`default_nettype wire

//--- src/feature_bank.sv
`timescale 1ns/10ps
`default_nettype none

`include "stream_buffer_macros.svh"

module feature_bank (
	input wire logic clk,
	input wire logic i_wen,
	input wire stream_buffer_pkg::bank_addr_t i_waddr,
	input wire stream_buffer_pkg::feature_t i_wdata,
	input wire logic i_ren,
	input wire stream_buffer_pkg::bank_addr_t i_raddr,
	output stream_buffer_pkg::feature_t o_rdata,
	output logic o_rvalid
);

	import stream_buffer_pkg::*;

	feature_t mem [0:`SB_DEPTH-1];
	bank_addr_t raddr_q;
	feature_t rdata_q;
	logic [`SB_READ_LAT-1:0] valid_pipe;

	always_ff @(posedge clk) begin
		if (i_wen) begin
			mem[i_waddr] <= i_wdata;
		end
	end

	// address register, array read, then one output stage.
	// a same cycle write to the read address still returns the old word.
	always_ff @(posedge clk) begin
		raddr_q <= i_raddr;
		rdata_q <= mem[raddr_q];
		o_rdata <= rdata_q;
	end

	always_ff @(posedge clk) begin
		valid_pipe <= {valid_pipe[`SB_READ_LAT-2:0], i_ren};
	end

	assign o_rvalid = valid_pipe[`SB_READ_LAT-1];

endmodule

`default_nettype wire

//--- src/stream_buffer.sv
`timescale 1ns/10ps
`default_nettype none

`include "stream_buffer_macros.svh"

module stream_buffer (
	input wire logic clk,
	input wire logic i_reset,
	input wire logic i_psel,
	input wire logic i_penable,
	input wire logic i_pwrite,
	input wire logic [3:0] i_paddr,
	input wire logic [31:0] i_pwdata,
	input wire logic i_ddr_wen,
	input wire stream_buffer_pkg::bank_addr_t i_ddr_waddr,
	input wire stream_buffer_pkg::feature_t i_ddr_wdata,
	input wire logic i_post_wen,
	input wire stream_buffer_pkg::bank_addr_t i_post_waddr,
	input wire stream_buffer_pkg::feature_t i_pool_wdata,
	input wire stream_buffer_pkg::feature_t i_eltwise_wdata,
	input wire logic i_eltwise_sel,
	output logic [31:0] o_prdata,
	output logic o_pready,
	output logic o_pslverr,
	output stream_buffer_pkg::feature_t o_feature_0,
	output stream_buffer_pkg::feature_t o_feature_1,
	output logic o_feature_valid,
	output logic o_done
);

	import stream_buffer_pkg::*;

	logic start;
	logic busy;
	logic walk_en;
	logic walk_last;
	logic ren;
	win_count_t windows;
	bank_addr_t raddr;
	feature_t post_wdata;

	stream_buffer_regs regs_i (
		.clk(clk),
		.i_reset(i_reset),
		.i_psel(i_psel),
		.i_penable(i_penable),
		.i_pwrite(i_pwrite),
		.i_paddr(i_paddr),
		.i_pwdata(i_pwdata),
		.i_busy(busy),
		.i_done_evt(o_done),
		.o_prdata(o_prdata),
		.o_pready(o_pready),
		.o_pslverr(o_pslverr),
		.o_start(start),
		.o_windows(windows)
	);

	stream_walk_ctrl ctrl_i (
		.clk(clk),
		.i_reset(i_reset),
		.i_start(start),
		.i_last(walk_last),
		.o_walk_en(walk_en),
		.o_busy(busy),
		.o_done(o_done)
	);

	window_addr_walker walker_i (
		.clk(clk),
		.i_reset(i_reset),
		.i_en(walk_en),
		.i_windows(windows),
		.o_raddr(raddr),
		.o_ren(ren),
		.o_last(walk_last)
	);

	// ----------------------------------------------------------------------
	// bank 0 takes the loader stream, bank 1 the pooling or eltwise result.
	// ----------------------------------------------------------------------

	assign post_wdata = i_eltwise_sel ? i_eltwise_wdata : i_pool_wdata;

	feature_bank bank0_i (
		.clk(clk),
		.i_wen(i_ddr_wen),
		.i_waddr(i_ddr_waddr),
		.i_wdata(i_ddr_wdata),
		.i_ren(ren),
		.i_raddr(raddr),
		.o_rdata(o_feature_0),
		.o_rvalid(o_feature_valid)
	);

	feature_bank bank1_i (
		.clk(clk),
		.i_wen(i_post_wen),
		.i_waddr(i_post_waddr),
		.i_wdata(post_wdata),
		.i_ren(ren),
		.i_raddr(raddr),
		.o_rdata(o_feature_1),
		.o_rvalid()
	);

	// done follows the last issued address by the read latency plus one.
	done_after_last: assert property (@(posedge clk) disable iff (i_reset)
		walk_last |-> ##(`SB_READ_LAT + 1) o_done)
		else $error("done pulse missing after the last walk address");

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS = 40,
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic o_reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// reset is released on a rising edge like every other synchronous input.
	initial begin
		o_reset <= 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		o_reset <= 1'b0;
	end

endmodule

`default_nettype wire

//--- sim/stream_buffer_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "stream_buffer_macros.svh"

module stream_buffer_tb;

	import stream_buffer_pkg::*;

	localparam int FILL_WORDS = 32;
	localparam int WAIT_LIMIT = 200;

	logic clk;
	logic i_reset;
	logic i_psel, i_penable, i_pwrite;
	logic [3:0] i_paddr;
	logic [31:0] i_pwdata;
	logic i_ddr_wen, i_post_wen, i_eltwise_sel;
	bank_addr_t i_ddr_waddr, i_post_waddr;
	feature_t i_ddr_wdata, i_pool_wdata, i_eltwise_wdata;
	logic [31:0] o_prdata;
	logic o_pready, o_pslverr;
	feature_t o_feature_0, o_feature_1;
	logic o_feature_valid, o_done;

	feature_t bank0_model [0:`SB_DEPTH-1];
	feature_t bank1_model [0:`SB_DEPTH-1];
	logic [31:0] lcg_state = 32'h1d9e;
	int word_idx;
	int expected_words;
	int stream_errors = 0;
	int reg_errors = 0;
	int wait_timeouts = 0;
	int tests_run = 0;
	int tests_failed = 0;
	bank_addr_t exp_addr;

	tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(8)) clock_gen_i (
		.clk(clk),
		.o_reset(i_reset)
	);

	stream_buffer stream_buffer_i (.*);

	function automatic feature_t next_word();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];
	endfunction

	// word k of a walk: line step innermost, then channel step, then window.
	function automatic bank_addr_t walk_addr(input int k);
		int w;
		int c;
		int l;
		w = k / 6;
		c = (k % 6) / 3;
		l = k % 3;
		return bank_addr_t'(5 * w + c + 2 * l);
	endfunction

	always @(posedge clk) begin
		if (i_reset || o_done) begin
			word_idx <= 0;
		end else if (o_feature_valid) begin
			word_idx <= word_idx + 1;
		end
	end

	assign exp_addr = walk_addr(word_idx);

	// ----------------------------------------------------------------------
	// stream checks, live on every walk.
	// ----------------------------------------------------------------------

	feature_0_matches: assert property (@(posedge clk) disable iff (i_reset)
		o_feature_valid |-> o_feature_0 == bank0_model[exp_addr])
		else begin
			$display("MISMATCH %0t o_feature_0 got %h expected %h", $time, o_feature_0,
				bank0_model[exp_addr]);
			stream_errors = stream_errors + 1;
		end

	feature_1_matches: assert property (@(posedge clk) disable iff (i_reset)
		o_feature_valid |-> o_feature_1 == bank1_model[exp_addr])
		else begin
			$display("MISMATCH %0t o_feature_1 got %h expected %h", $time, o_feature_1,
				bank1_model[exp_addr]);
			stream_errors = stream_errors + 1;
		end

	stream_no_gaps: assert property (@(posedge clk) disable iff (i_reset)
		o_feature_valid && (word_idx < expected_words - 1) |=> o_feature_valid)
		else begin
			$display("feature stream broke off early at %0t", $time);
			stream_errors = stream_errors + 1;
		end

	done_after_last_word: assert property (@(posedge clk) disable iff (i_reset)
		o_feature_valid && (word_idx == expected_words - 1) |=> o_done)
		else begin
			$display("no done pulse in the cycle after the last word at %0t", $time);
			stream_errors = stream_errors + 1;
		end

	// a done lasting two cycles also lands here, since the count clears after done.
	done_word_count: assert property (@(posedge clk) disable iff (i_reset)
		o_done |-> word_idx == expected_words)
		else begin
			$display("MISMATCH %0t word count got %0d expected %0d", $time, word_idx,
				expected_words);
			stream_errors = stream_errors + 1;
		end

	task automatic report_timeout(input string reason);
		$display("TIMEOUT at %0t: %s", $time, reason);
		wait_timeouts = wait_timeouts + 1;
	endtask

	task automatic expect_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("MISMATCH %0t %s got %h expected %h", $time, name, got, exp);
			reg_errors = reg_errors + 1;
		end
	endtask

	// setup phase, then access phase until pready. reads compare prdata with data.
	task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] data,
			input logic exp_err, input string name);
		int waited;
		i_psel <= 1'b1;
		i_penable <= 1'b0;
		i_pwrite <= wr;
		i_paddr <= addr;
		i_pwdata <= data;
		@(posedge clk);
		i_penable <= 1'b1;
		waited = 0;
		do begin
			@(negedge clk);
			waited = waited + 1;
		end while (!o_pready && waited < WAIT_LIMIT);
		if (!o_pready) begin
			report_timeout("the APB slave never raised pready");
		end
		if (!wr) begin
			expect_value(name, o_prdata, data);
		end
		expect_value($sformatf("%s pslverr", name), 32'(o_pslverr), 32'(exp_err));
		@(posedge clk);
		i_psel <= 1'b0;
		i_penable <= 1'b0;
	endtask

	task automatic wait_for_done();
		int waited;
		waited = 0;
		do begin
			@(negedge clk);
			waited = waited + 1;
		end while (!o_done && waited < WAIT_LIMIT);
		if (!o_done) begin
			report_timeout("o_done never rose after the start command");
		end
		@(posedge clk);
	endtask

	// bank 1 takes the eltwise word at odd addresses and the pool word at even ones.
	task automatic fill_banks(input int count);
		bank_addr_t addr;
		feature_t pool_word;
		feature_t eltwise_word;
		for (int a = 0; a < count; a++) begin
			addr = bank_addr_t'(a);
			pool_word = next_word();
			eltwise_word = next_word();
			bank0_model[addr] = next_word();
			bank1_model[addr] = addr[0] ? eltwise_word : pool_word;
			i_ddr_wen <= 1'b1;
			i_ddr_waddr <= addr;
			i_ddr_wdata <= bank0_model[addr];
			i_post_wen <= 1'b1;
			i_post_waddr <= addr;
			i_pool_wdata <= pool_word;
			i_eltwise_wdata <= eltwise_word;
			i_eltwise_sel <= addr[0];
			@(posedge clk);
		end
		i_ddr_wen <= 1'b0;
		i_post_wen <= 1'b0;
	endtask

	task automatic report_test(input string name, input int errors_before);
		int failed;
		failed = stream_errors + reg_errors + wait_timeouts - errors_before;
		tests_run = tests_run + 1;
		if (failed == 0) begin
			$display("test %s: passed", name);
		end else begin
			tests_failed = tests_failed + 1;
			$display("test %s: FAILED with %0d errors", name, failed);
		end
	endtask

	initial begin
		int waited;
		int mark;
		i_psel <= 1'b0;
		i_penable <= 1'b0;
		i_pwrite <= 1'b0;
		i_paddr <= '0;
		i_pwdata <= '0;
		i_ddr_wen <= 1'b0;
		i_ddr_waddr <= '0;
		i_ddr_wdata <= '0;
		i_post_wen <= 1'b0;
		i_post_waddr <= '0;
		i_pool_wdata <= '0;
		i_eltwise_wdata <= '0;
		i_eltwise_sel <= 1'b0;
		expected_words <= 0;
		waited = 0;
		do begin
			@(negedge clk);
			waited = waited + 1;
		end while (i_reset && waited < WAIT_LIMIT);
		if (i_reset) begin
			report_timeout("reset was never released");
		end

		mark = 0;
		expect_value("o_done", 32'(o_done), 32'd0);
		expect_value("o_feature_valid", 32'(o_feature_valid), 32'd0);
		expect_value("o_pslverr", 32'(o_pslverr), 32'd0);
		@(posedge clk);
		apb_access(1'b0, `SB_REG_WINDOWS, 32'd0, 1'b0, "WINDOWS");
		apb_access(1'b0, `SB_REG_STATUS, 32'd0, 1'b0, "STATUS");
		report_test("reset", mark);

		fill_banks(FILL_WORDS);
		mark = stream_errors + reg_errors + wait_timeouts;
		apb_access(1'b1, `SB_REG_WINDOWS, 32'd3, 1'b0, "WINDOWS");
		expected_words <= 24;
		apb_access(1'b1, `SB_REG_CTRL, 32'd1, 1'b0, "CTRL");
		apb_access(1'b0, `SB_REG_STATUS, 32'h1, 1'b0, "STATUS busy");
		wait_for_done();
		report_test("walk order and bank data", mark);

		// the start here also opens the walk that the error test runs against.
		mark = stream_errors + reg_errors + wait_timeouts;
		apb_access(1'b0, `SB_REG_STATUS, 32'h2, 1'b0, "STATUS done");
		apb_access(1'b1, `SB_REG_CTRL, 32'd1, 1'b0, "CTRL");
		apb_access(1'b0, `SB_REG_STATUS, 32'h1, 1'b0, "STATUS cleared");
		report_test("done and status", mark);

		mark = stream_errors + reg_errors + wait_timeouts;
		apb_access(1'b1, `SB_REG_WINDOWS, 32'd9, 1'b1, "WINDOWS busy write");
		apb_access(1'b0, `SB_REG_WINDOWS, 32'd3, 1'b0, "WINDOWS kept");
		apb_access(1'b1, `SB_REG_STATUS, 32'd0, 1'b1, "STATUS write");
		apb_access(1'b0, 4'hc, 32'd0, 1'b1, "offset 0xc read");
		apb_access(1'b1, 4'hc, 32'd0, 1'b1, "offset 0xc write");
		wait_for_done();
		report_test("apb errors", mark);

		mark = stream_errors + reg_errors + wait_timeouts;
		apb_access(1'b1, `SB_REG_WINDOWS, 32'd0, 1'b0, "WINDOWS");
		expected_words <= 6;
		apb_access(1'b1, `SB_REG_CTRL, 32'd1, 1'b0, "CTRL");
		wait_for_done();
		apb_access(1'b0, `SB_REG_STATUS, 32'h2, 1'b0, "STATUS done");
		report_test("repeated walk", mark);

		$display("%0d tests run, %0d failed, %0d stream errors, %0d register errors, %0d timeouts",
			tests_run, tests_failed, stream_errors, reg_errors, wait_timeouts);
		if (stream_errors + reg_errors + wait_timeouts == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- stream_buffer.f
+incdir+include
src/stream_buffer_pkg.sv
src/stream_buffer_regs.sv
src/stream_walk_ctrl.sv
src/window_addr_walker.sv
src/feature_bank.sv
src/stream_buffer.sv
sim/tb_clock_gen.sv
sim/stream_buffer_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module stream_buffer_tb -f stream_buffer.f
./obj_dir/Vstream_buffer_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
	exit 1
fi
grep -q "Simulation completed successfully" sim.log
